//--- Bender.yml
package:
  name: core_glue

sources:
  - target: rtl
    files:
      - source/core_cfg_pkg.sv
      - source/player_io_pkg.sv
      - source/setting_regs.sv
      - source/pad_router.sv
      - source/reset_pulser.sv
      - source/coin_pulser.sv
      - source/video_formatter.sv
      - source/core_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/core_top_tb.sv

//--- flist.f
source/core_cfg_pkg.sv
source/player_io_pkg.sv
source/setting_regs.sv
source/pad_router.sv
source/reset_pulser.sv
source/coin_pulser.sv
source/video_formatter.sv
source/core_top.sv
sim/tb_clock_gen.sv
sim/core_top_tb.sv

//--- sim/core_top_tb.sv
/*
 * table driven testbench for the control and video glue
 * register, routing, analog stick and video rows in a loop
 * directed coin, manual reset and sync pulse sequences
 * watchdog, check task and error summary
 */
`default_nettype none

module core_top_tb
    import core_cfg_pkg::*;
    import player_io_pkg::*;
();

    // one table row, inputs first then expected outputs
    typedef struct packed {
        logic        wr_en;
        logic [31:0] wr_addr;
        logic [31:0] wr_data;
        logic [31:0] rd_addr;
        key_bits_t   key;
        pad_state_t  snac_p1;
        pad_state_t  snac_p2;
        video_in_t   video;
        logic [31:0] exp_rd;
        game_ctrl_t  exp_ctrl;
        video_out_t  exp_video;
        logic [1:0]  rand_pad;
    } stim_row_t;

    // pixel 5A3 and its doubled form
    localparam video_in_t  pix_on     = {12'h5A3, 4'b0000};
    localparam video_in_t  pix_hblank = {12'h5A3, 4'b1000};
    localparam video_in_t  pix_vblank = {12'h5A3, 4'b0100};
    localparam video_in_t  pix_sync   = {12'h5A3, 4'b0011};
    localparam video_out_t out_on     = {24'h55AA33, 1'b1, 2'b00};
    localparam video_out_t out_dark   = {24'h000000, 1'b1, 2'b00};
    localparam video_out_t out_off    = {24'h000000, 1'b0, 2'b00};
    // stick at rest, no direction either way
    localparam pad_state_t pad_idle   = {16'h0000, 32'h0000_8080};

    logic        clk_74a;
    logic        rst;
    logic [31:0] bridge_addr;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic [31:0] bridge_rd_data;
    key_bits_t   cont1_key;
    pad_state_t  snac_p1;
    pad_state_t  snac_p2;
    video_in_t   video_in;
    video_out_t  video_out;
    game_ctrl_t  game_controls;
    logic        core_reset;

    stim_row_t   rows[$];
    string       row_names[$];
    int          row_count   = 0;
    int          check_count = 0;
    int          error_count = 0;
    int unsigned seed_sink;

    tb_clock_gen #(.PERIOD(40)) u_clock_gen (.clk(clk_74a));

    core_top #(
        .RESET_HOLD_CYCLES (16),
        .COIN_PULSE_CYCLES (8)
    ) u_core_top (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .snac_p1        (snac_p1),
        .snac_p2        (snac_p2),
        .video_in       (video_in),
        .video_out      (video_out),
        .game_controls  (game_controls),
        .core_reset     (core_reset)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // drive slot, just after the rising edge
    task automatic next_cycle();
        @(posedge clk_74a);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // register row, pads at rest so game_controls stays zero
    task automatic add_cfg_row(input string name, input logic wr, input logic [31:0] addr,
                               input logic [31:0] data, input logic [31:0] rd_addr,
                               input logic [31:0] exp_rd, input video_in_t vid,
                               input video_out_t exp_vid);
        stim_row_t row;
        row           = '0;
        row.wr_en     = wr;
        row.wr_addr   = addr;
        row.wr_data   = data;
        row.rd_addr   = rd_addr;
        row.snac_p1   = pad_idle;
        row.snac_p2   = pad_idle;
        row.video     = vid;
        row.exp_rd    = exp_rd;
        row.exp_video = exp_vid;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    // pad row, no write, unmapped read, visible pixel
    task automatic add_pad_row(input string name, input logic [15:0] key,
                               input logic [15:0] p1_btn, input logic [15:0] p2_btn,
                               input game_ctrl_t exp_ctrl, input logic [1:0] rand_pad);
        stim_row_t row;
        row           = '0;
        row.key       = key_bits_t'(key);
        row.snac_p1   = {p1_btn, 32'h0};
        row.snac_p2   = {p2_btn, 32'h0};
        row.video     = pix_on;
        row.exp_ctrl  = exp_ctrl;
        row.exp_video = out_on;
        row.rand_pad  = rand_pad;
        rows.push_back(row);
        row_names.push_back(name);
    endtask

    task automatic apply_row(input int idx);
        stim_row_t   row;
        game_ctrl_t  exp_ctrl;
        logic [31:0] rnd;
        row      = rows[idx];
        exp_ctrl = row.exp_ctrl;
        // random stick on the selected pad, directions from the thresholds
        if (row.rand_pad != 2'd0) begin
            rnd = $urandom;
            if (row.rand_pad == 2'd1) begin
                row.snac_p1.joy[15:0] = rnd[15:0];
            end else begin
                row.snac_p2.joy[15:0] = rnd[15:0];
            end
            exp_ctrl.up    = rnd[15:8] < stick_low;
            exp_ctrl.down  = rnd[15:8] > stick_high;
            exp_ctrl.left  = rnd[7:0] < stick_low;
            exp_ctrl.right = rnd[7:0] > stick_high;
        end
        next_cycle();
        bridge_addr    = row.wr_addr;
        bridge_wr      = row.wr_en;
        bridge_wr_data = row.wr_data;
        cont1_key      = row.key;
        snac_p1        = row.snac_p1;
        snac_p2        = row.snac_p2;
        video_in       = row.video;
        next_cycle();
        bridge_wr   = 1'b0;
        bridge_addr = row.rd_addr;
        next_cycle();
        check_value({row_names[idx], " rd_data"}, row.exp_rd, bridge_rd_data);
        check_value({row_names[idx], " controls"}, 32'(exp_ctrl), 32'(game_controls));
        check_value({row_names[idx], " video"}, 32'(row.exp_video), 32'(video_out));
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        next_cycle();
        bridge_addr    = addr;
        bridge_wr      = 1'b1;
        bridge_wr_data = data;
        next_cycle();
        bridge_wr = 1'b0;
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic build_table();
        // dip word fields one by one
        add_cfg_row("lives", 1, addr_lives, 32'd3, addr_dips, 32'h0000_3000, pix_on, out_on);
        add_cfg_row("difficulty", 1, addr_difficulty, 32'd5, addr_dips, 32'h0000_3028,
                    pix_on, out_on);
        add_cfg_row("bonus", 1, addr_bonus, 32'd6, addr_dips, 32'h0000_302E, pix_on, out_on);
        add_cfg_row("demo_sounds", 1, addr_demo_sounds, 32'd1, addr_dips, 32'h0000_B02E,
                    pix_on, out_on);
        add_cfg_row("unmapped", 1, 32'h1234_0000, 32'hFFFF_FFFF, 32'h1234_0000, 32'h0,
                    pix_on, out_on);
        // bit 16 of a config write is not the enable
        add_cfg_row("adapter_cfg", 1, addr_adapter_cfg, 32'h0001_1312, addr_adapter_cfg,
                    32'h0000_1312, pix_on, out_on);
        add_cfg_row("adapter_ena", 1, addr_dips, 32'd1, addr_adapter_cfg, 32'h0001_1312,
                    pix_on, out_dark);
        add_cfg_row("dips_with_ena", 0, 32'h0, 32'h0, addr_dips, 32'h0000_B02E,
                    pix_on, out_dark);
        add_cfg_row("cfg_clear", 1, addr_adapter_cfg, 32'h0, addr_adapter_cfg, 32'h0001_0000,
                    pix_on, out_on);
        add_cfg_row("hblank", 0, 32'h0, 32'h0, addr_adapter_cfg, 32'h0001_0000,
                    pix_hblank, out_off);
        add_cfg_row("vblank", 0, 32'h0, 32'h0, addr_adapter_cfg, 32'h0001_0000,
                    pix_vblank, out_off);
        // native pad, adapter on but no type set
        add_pad_row("native_type0", 16'h8011, 16'h0002, 16'h0004, 7'b1000110, 2'd0);
        // digital type set, then adapter off still reads the native pad
        add_cfg_row("assign_p1_to_p1", 1, addr_adapter_cfg, 32'h0000_0001, addr_adapter_cfg,
                    32'h0001_0001, pix_on, out_on);
        add_cfg_row("adapter_off", 1, addr_dips, 32'd0, addr_dips, 32'h0000_B02E,
                    pix_on, out_on);
        add_pad_row("native_disabled", 16'h0009, 16'h0002, 16'h0004, 7'b1001000, 2'd0);
        // digital adapter, each player assignment
        add_cfg_row("adapter_on", 1, addr_dips, 32'd1, addr_dips, 32'h0000_B02E,
                    pix_on, out_on);
        add_pad_row("route_p1_to_p1", 16'h0001, 16'h0012, 16'h0004, 7'b0100100, 2'd0);
        add_cfg_row("assign_p1_to_p2", 1, addr_adapter_cfg, 32'h0000_0101, addr_adapter_cfg,
                    32'h0001_0101, pix_on, out_on);
        add_pad_row("route_p1_to_p2", 16'h8000, 16'h0012, 16'h0004, 7'b0000010, 2'd0);
        add_cfg_row("assign_both", 1, addr_adapter_cfg, 32'h0000_0201, addr_adapter_cfg,
                    32'h0001_0201, pix_on, out_on);
        add_pad_row("route_both", 16'h0001, 16'h0008, 16'h0004, 7'b0001000, 2'd0);
        add_cfg_row("assign_swapped", 1, addr_adapter_cfg, 32'h0000_0301, addr_adapter_cfg,
                    32'h0001_0301, pix_on, out_on);
        add_pad_row("route_swapped", 16'h0001, 16'h0012, 16'h8004, 7'b0010010, 2'd0);
        // analog types, pad direction buttons must be overridden
        add_cfg_row("analog_a", 1, addr_adapter_cfg, 32'h0000_0012, addr_adapter_cfg,
                    32'h0001_0012, pix_on, out_on);
        for (int i = 0; i < 6; i++) begin
            add_pad_row("analog_a_stick", 16'h0001, 16'h001F, 16'h0000, 7'b0000100, 2'd1);
        end
        add_cfg_row("analog_b", 1, addr_adapter_cfg, 32'h0000_0313, addr_adapter_cfg,
                    32'h0001_0313, pix_on, out_on);
        for (int i = 0; i < 6; i++) begin
            add_pad_row("analog_b_stick", 16'h0001, 16'h0000, 16'h801F, 7'b0000110, 2'd2);
        end
    endtask

    ////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////

    initial begin
        wait (row_count > 0);
        repeat (row_count * 40 + 200) @(posedge clk_74a);
        $display("timeout: the run did not finish within %0d cycles", row_count * 40 + 200);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int   highs;
        int   runs;
        int   first;
        logic prev;
        seed_sink      = $urandom(32'h9859_c9b9);
        rst            = 1'b1;
        bridge_addr    = '0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        snac_p1        = pad_idle;
        snac_p2        = pad_idle;
        video_in       = pix_on;
        build_table();
        row_count = rows.size();

        repeat (3) @(posedge clk_74a);
        #2;
        rst = 1'b0;

        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end

        // coin from the native select key
        bridge_write(addr_dips, 32'd0);
        cont1_key = key_bits_t'(16'h4000);
        repeat (3) next_cycle();
        cont1_key = '0;
        highs = 0;
        runs  = 0;
        first = -1;
        prev  = 1'b0;
        for (int i = 1; i <= 20; i++) begin
            next_cycle();
            if (game_controls.coin) begin
                highs = highs + 1;
                if (first < 0) begin
                    first = i;
                end
                if (!prev) begin
                    runs = runs + 1;
                end
            end
            prev = game_controls.coin;
        end
        check_value("coin_pulse_length", 32'd8, highs);
        check_value("coin_pulse_runs", 32'd1, runs);
        // release at the pad, one cycle routing, two in the pulser
        check_value("coin_pulse_start", 32'd3, first);

        // manual reset, second toggle inside the hold
        next_cycle();
        bridge_addr    = addr_reset_toggle;
        bridge_wr      = 1'b1;
        bridge_wr_data = '0;
        highs = 0;
        runs  = 0;
        prev  = 1'b0;
        for (int i = 0; i < 40; i++) begin
            next_cycle();
            bridge_wr = (i == 4);
            if (core_reset) begin
                highs = highs + 1;
                if (!prev) begin
                    runs = runs + 1;
                end
            end
            prev = core_reset;
        end
        check_value("reset_hold_length", 32'd16, highs);
        check_value("reset_hold_runs", 32'd1, runs);

        // both syncs rise together and stay high
        video_in = pix_sync;
        highs = 0;
        runs  = 0;
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            highs = highs + video_out.hs;
            runs  = runs + video_out.vs;
        end
        video_in = pix_on;
        check_value("hs_pulse_cycles", 32'd1, highs);
        check_value("vs_pulse_cycles", 32'd1, runs);

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
/*
 * free running testbench clock
 */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // starts low, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- source/coin_pulser.sv
/*
 * coin release stretched into a long coin pulse
 * other control bits registered alongside
 */
`default_nettype none

module coin_pulser
    import player_io_pkg::*;
#(
    parameter int unsigned COIN_PULSE_CYCLES = 1_048_575
) (
    input  wire logic clk_74a,
    input  wire logic rst,
    input  wire game_ctrl_t routed,
    output game_ctrl_t controls
);

    localparam int CNT_W = $clog2(COIN_PULSE_CYCLES + 1);

    logic             coin_prev;
    logic             coin_fall;
    logic [CNT_W-1:0] count;

    assign coin_fall = coin_prev && !routed.coin;

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            coin_prev <= 1'b0;
            count     <= '0;
            controls  <= '0;
        end else begin
            coin_prev <= routed.coin;
            // same delay as the coin bit
            controls       <= routed;
            controls.coin  <= 1'b0;
            if (count != '0) begin
                count         <= count - 1'b1;
                controls.coin <= 1'b1;
            end else if (coin_fall) begin
                // release edge, ignored while counting
                count <= CNT_W'(COIN_PULSE_CYCLES);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/core_cfg_pkg.sv
/*
 * bridge register addresses for the core settings
 * packed settings word shared by the side modules
 * state encoding of the manual reset machine
 */
`default_nettype none

package core_cfg_pkg;

    // game settings, one address per field
    localparam logic [31:0] addr_lives        = 32'h2000_0000;
    localparam logic [31:0] addr_difficulty   = 32'h3000_0000;
    localparam logic [31:0] addr_bonus        = 32'h4000_0000;
    localparam logic [31:0] addr_demo_sounds  = 32'h5000_0000;

    // manual reset, any write flips the toggle
    localparam logic [31:0] addr_reset_toggle = 32'h8000_0000;

    // dip word on read, adapter enable on write
    localparam logic [31:0] addr_dips         = 32'hF200_0000;
    localparam logic [31:0] addr_adapter_cfg  = 32'hF700_0000;

    typedef struct packed {
        logic [1:0] lives;
        logic [2:0] difficulty;
        logic [2:0] bonus;
        logic       demo_sounds;
        logic       adapter_ena;
        logic [4:0] snac_type;
        logic [1:0] snac_assign;
        logic       blank_screen;
        logic       reset_toggle;
    } game_settings_t;

    typedef enum logic {
        reset_idle,
        reset_hold
    } reset_state_t;

endpackage

`default_nettype wire

//--- source/core_top.sv
/*
 * control and video glue top level
 * settings, player 1 routing, manual reset, coin and video output
 */
`default_nettype none

module core_top
    import core_cfg_pkg::*;
    import player_io_pkg::*;
#(
    // full length holds, lowered for simulation
    parameter int unsigned RESET_HOLD_CYCLES = 2_097_151,
    parameter int unsigned COIN_PULSE_CYCLES = 1_048_575
) (
    input  wire logic        clk_74a,
    input  wire logic        rst,
    // bridge bus
    input  wire logic [31:0] bridge_addr,
    input  wire logic        bridge_wr,
    input  wire logic [31:0] bridge_wr_data,
    output logic      [31:0] bridge_rd_data,
    // pads
    input  wire key_bits_t   cont1_key,
    input  wire pad_state_t  snac_p1,
    input  wire pad_state_t  snac_p2,
    // video
    input  wire video_in_t   video_in,
    output video_out_t       video_out,
    // to the game
    output game_ctrl_t       game_controls,
    output logic             core_reset
);

    game_settings_t settings;
    game_ctrl_t     routed;
    logic           manual_hold;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    setting_regs u_setting_regs (
        .clk_74a        (clk_74a),
        .rst            (rst),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .settings       (settings)
    );

    pad_router u_pad_router (
        .clk_74a   (clk_74a),
        .rst       (rst),
        .settings  (settings),
        .cont1_key (cont1_key),
        .snac_p1   (snac_p1),
        .snac_p2   (snac_p2),
        .routed    (routed)
    );

    ////////////////////////////////////////
    // processing
    ////////////////////////////////////////

    reset_pulser #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) u_reset_pulser (
        .clk_74a      (clk_74a),
        .rst          (rst),
        .reset_toggle (settings.reset_toggle),
        .hold         (manual_hold)
    );

    coin_pulser #(
        .COIN_PULSE_CYCLES (COIN_PULSE_CYCLES)
    ) u_coin_pulser (
        .clk_74a  (clk_74a),
        .rst      (rst),
        .routed   (routed),
        .controls (game_controls)
    );

    // game held in reset by either source
    assign core_reset = rst || manual_hold;

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    video_formatter u_video_formatter (
        .clk_74a   (clk_74a),
        .rst       (rst),
        .settings  (settings),
        .video_in  (video_in),
        .video_out (video_out)
    );

endmodule

`default_nettype wire

//--- source/pad_router.sv
/*
 * player 1 control routing
 * native pad or adapter pad, analog stick to digital directions
 */
`default_nettype none

module pad_router
    import core_cfg_pkg::*;
    import player_io_pkg::*;
(
    input  wire logic   clk_74a,
    input  wire logic   rst,
    input  wire game_settings_t settings,
    input  wire key_bits_t   cont1_key,
    input  wire pad_state_t  snac_p1,
    input  wire pad_state_t  snac_p2,
    output game_ctrl_t  routed
);

    // key bitmap to game word, select is the coin button
    function automatic game_ctrl_t key_to_ctrl(input key_bits_t key);
        game_ctrl_t ctrl;
        ctrl.up    = key.up;
        ctrl.down  = key.down;
        ctrl.left  = key.left;
        ctrl.right = key.right;
        ctrl.fire  = key.a;
        ctrl.start = key.start;
        ctrl.coin  = key.select;
        return ctrl;
    endfunction

    // adapter pad, directions from the stick when analog
    function automatic game_ctrl_t pad_to_ctrl(input pad_state_t pad, input logic analog);
        key_bits_t  keys;
        logic [7:0] stick_x;
        logic [7:0] stick_y;
        game_ctrl_t ctrl;
        keys    = key_bits_t'(pad.btn);
        stick_x = pad.joy[7:0];
        stick_y = pad.joy[15:8];
        ctrl    = key_to_ctrl(keys);
        if (analog) begin
            ctrl.up    = stick_y < stick_low;
            ctrl.down  = stick_y > stick_high;
            ctrl.left  = stick_x < stick_low;
            ctrl.right = stick_x > stick_high;
        end
        return ctrl;
    endfunction

    logic       snac_analog;
    logic       use_native;
    game_ctrl_t native_ctrl;
    game_ctrl_t p1_ctrl;
    game_ctrl_t p2_ctrl;
    game_ctrl_t next_ctrl;

    assign snac_analog = (settings.snac_type == snac_analog_a) ||
                         (settings.snac_type == snac_analog_b);

    // adapter off or no controller type set
    assign use_native  = !settings.adapter_ena || (settings.snac_type == 5'd0);

    assign native_ctrl = key_to_ctrl(cont1_key);
    assign p1_ctrl     = pad_to_ctrl(snac_p1, snac_analog);
    assign p2_ctrl     = pad_to_ctrl(snac_p2, snac_analog);

    always_comb begin
        if (use_native) begin
            next_ctrl = native_ctrl;
        end else begin
            case (snac_route_t'(settings.snac_assign))
                route_p1_to_p1, route_both: next_ctrl = p1_ctrl;
                // adapter pad 1 belongs to player 2 here
                route_p1_to_p2:             next_ctrl = native_ctrl;
                route_swapped:              next_ctrl = p2_ctrl;
                default:                    next_ctrl = native_ctrl;
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            routed <= '0;
        end else begin
            routed <= next_ctrl;
        end
    end

endmodule

`default_nettype wire

//--- source/player_io_pkg.sv
/*
 * pad, key bitmap and game control word types
 * game video in and formatted video out
 * stick thresholds, analog adapter types and player routing
 */
`default_nettype none

package player_io_pkg;

    // adapter pad, joy holds x in 7:0 and y in 15:8
    typedef struct packed {
        logic [15:0] btn;
        logic [31:0] joy;
    } pad_state_t;

    // platform key bitmap, start is the msb
    typedef struct packed {
        logic start;
        logic select;
        logic r3;
        logic l3;
        logic r2;
        logic l2;
        logic r1;
        logic l1;
        logic y;
        logic x;
        logic b;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
    } key_bits_t;

    // control word seen by the game, coin in bit 0
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic start;
        logic coin;
    } game_ctrl_t;

    typedef struct packed {
        logic [11:0] rgb12;
        logic        hblank;
        logic        vblank;
        logic        hs;
        logic        vs;
    } video_in_t;

    typedef struct packed {
        logic [23:0] rgb24;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

    // stick is unsigned, idle near 80
    localparam logic [7:0] stick_low  = 8'h40;
    localparam logic [7:0] stick_high = 8'hC0;

    localparam logic [4:0] snac_analog_a = 5'h12;
    localparam logic [4:0] snac_analog_b = 5'h13;

    typedef enum logic [1:0] {
        route_p1_to_p1,
        route_p1_to_p2,
        route_both,
        route_swapped
    } snac_route_t;

endpackage

`default_nettype wire

//--- source/reset_pulser.sv
/*
 * manual reset from the bridge toggle
 * fixed length hold after each toggle change
 */
`default_nettype none

module reset_pulser
    import core_cfg_pkg::*;
#(
    parameter int unsigned RESET_HOLD_CYCLES = 2_097_151
) (
    input  wire logic clk_74a,
    input  wire logic rst,
    input  wire logic reset_toggle,
    output logic      hold
);

    localparam int CNT_W = (RESET_HOLD_CYCLES > 1) ? $clog2(RESET_HOLD_CYCLES) : 1;

    reset_state_t     state;
    logic             last_toggle;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            state       <= reset_idle;
            last_toggle <= 1'b0;
            count       <= '0;
        end else begin
            // tracked always, so a toggle during hold is absorbed
            last_toggle <= reset_toggle;
            case (state)
                reset_idle: begin
                    if (reset_toggle != last_toggle) begin
                        state <= reset_hold;
                        count <= CNT_W'(RESET_HOLD_CYCLES - 1);
                    end
                end
                reset_hold: begin
                    if (count == '0) begin
                        state <= reset_idle;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= reset_idle;
            endcase
        end
    end

    assign hold = (state == reset_hold);

endmodule

`default_nettype wire

//--- source/setting_regs.sv
/*
 * bridge settings register file
 * write decode into the settings word, combinational read mux
 */
`default_nettype none

module setting_regs
    import core_cfg_pkg::*;
(
    input  wire logic           clk_74a,
    input  wire logic           rst,
    input  wire logic [31:0]    bridge_addr,
    input  wire logic           bridge_wr,
    input  wire logic [31:0]    bridge_wr_data,
    output logic      [31:0]    bridge_rd_data,
    output game_settings_t      settings
);

    logic [15:0] dip_word;
    logic [31:0] cfg_word;

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            settings <= '0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                addr_lives:        settings.lives       <= bridge_wr_data[1:0];
                addr_difficulty:   settings.difficulty  <= bridge_wr_data[2:0];
                addr_bonus:        settings.bonus       <= bridge_wr_data[2:0];
                addr_demo_sounds:  settings.demo_sounds <= bridge_wr_data[0];
                addr_dips:         settings.adapter_ena <= bridge_wr_data[0];
                addr_reset_toggle: settings.reset_toggle <= ~settings.reset_toggle;
                addr_adapter_cfg: begin
                    // same layout as the read word, enable stays put
                    settings.snac_type    <= bridge_wr_data[4:0];
                    settings.snac_assign  <= bridge_wr_data[9:8];
                    settings.blank_screen <= bridge_wr_data[12];
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // read side
    ////////////////////////////////////////

    // dip order as the game expects it
    assign dip_word = {settings.demo_sounds, 1'b0, settings.lives, 6'b0,
                       settings.difficulty, settings.bonus};

    assign cfg_word = {15'b0, settings.adapter_ena, 3'b0, settings.blank_screen,
                       2'b0, settings.snac_assign, 3'b0, settings.snac_type};

    // no wait states, data follows the address
    always_comb begin
        case (bridge_addr)
            addr_dips:        bridge_rd_data = {16'h0, dip_word};
            addr_adapter_cfg: bridge_rd_data = cfg_word;
            default:          bridge_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/video_formatter.sv
/*
 * 12-bit game pixels to 24-bit output
 * data enable, adapter screen blank, sync edge pulses
 */
`default_nettype none

module video_formatter
    import core_cfg_pkg::*;
    import player_io_pkg::*;
(
    input  wire logic     clk_74a,
    input  wire logic     rst,
    input  wire game_settings_t settings,
    input  wire video_in_t     video_in,
    output video_out_t    video_out
);

    logic        de_next;
    logic        screen_off;
    logic [23:0] rgb_next;
    logic [23:0] rgb_q;
    logic        de_q;
    logic        hs_q;
    logic        vs_q;
    logic        hs_prev;
    logic        vs_prev;

    assign de_next    = !(video_in.hblank || video_in.vblank);
    assign screen_off = settings.blank_screen && settings.adapter_ena;

    // each nibble doubled, r in the top byte
    assign rgb_next = (de_next && !screen_off) ?
                      {{2{video_in.rgb12[11:8]}}, {2{video_in.rgb12[7:4]}},
                       {2{video_in.rgb12[3:0]}}} : 24'h0;

    // pixel data
    always_ff @(posedge clk_74a) begin
        rgb_q <= rgb_next;
    end

    always_ff @(posedge clk_74a) begin
        if (rst) begin
            de_q    <= 1'b0;
            hs_q    <= 1'b0;
            vs_q    <= 1'b0;
            hs_prev <= 1'b0;
            vs_prev <= 1'b0;
        end else begin
            de_q    <= de_next;
            // one cycle on each rising sync edge
            hs_q    <= video_in.hs && !hs_prev;
            vs_q    <= video_in.vs && !vs_prev;
            hs_prev <= video_in.hs;
            vs_prev <= video_in.vs;
        end
    end

    assign video_out = '{rgb24: rgb_q, de: de_q, hs: hs_q, vs: vs_q};

endmodule

`default_nettype wire
